//--- src.f
verilog/routerPkg.sv
verilog/flitFifo.sv
verilog/packetTimer.sv
verilog/outputArbiter.sv
verilog/routerOutputPort.sv
sim/router_assert.sv
sim/tbRouter.sv

//--- Makefile
# Verilator build of the router output port and its testbench.

LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module tbRouter -f src.f

# the run passes only if the log holds the pass message.
run: build
	./obj_dir/VtbRouter | tee $(LOG)
	grep -q "all tests passed" $(LOG)

lint:
	verilator --lint-only --timing --assert -Wall --top-module tbRouter -f src.f

clean:
	rm -rf obj_dir $(LOG)

//--- sim/tbRouter.sv
`timescale 1ns/10ps

module tbRouter;

  import routerPkg::*;

  localparam int clkPeriod = 10;
  localparam int resetCycles = 10;
  localparam int watchdogCycles = 2000;  // the whole run needs only a few hundred cycles.

  logic     clk;
  logic     rst;
  flit_t    inFlit [numPorts];
  portVec_t inValid;
  flit_t    outFlit;
  logic     outValid;
  portVec_t grant;

  flit_t    expQ [numPorts][$];  // flits sent but not yet seen, per input port.
  portVec_t prevGrant;
  int       pktLeft;
  int       pktPort;
  string    headSeq;  // source ports of the packet heads, in departure order.
  int       errorCount;

  routerOutputPort dut0 (
    .clk      (clk),
    .rst      (rst),
    .inFlit   (inFlit),
    .inValid  (inValid),
    .outFlit  (outFlit),
    .outValid (outValid),
    .grant    (grant)
  );

  initial
  begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  task automatic failRun(input string msg);
    errorCount++;
    $display("%s", msg);
    $display("tests failed");
    $fatal(1, "stopping at the first failure");
  endtask

  function automatic int portIndex(input portVec_t v);
    int idx;
    idx = -1;
    for (int i = 0; i < numPorts; i++)
    begin
      if (v[i])
        idx = i;
    end
    return idx;
  endfunction

  function automatic flit_t makeFlit(input int port, input int idx, input int len);
    flit_t f;
    f.kind = (idx == 0) ? kindHead : kindBody;
    f.len = (idx == 0) ? lenWidth'(len) : '0;  // only a header carries the length.
    f.srcPort = portIdWidth'(port);
    f.data = dataWidth'($urandom);
    return f;
  endfunction

  function automatic int pendingFlits();
    int n;
    n = 0;
    for (int p = 0; p < numPorts; p++)
      n += expQ[p].size();
    return n;
  endfunction

  // One packet per port in mask, all starting in the same cycle.
  // A len of 0 picks a random length per port, and gap idle cycles follow each flit but the last.
  task automatic sendPackets(input portVec_t mask, input int len, input int gap);
    int lens [numPorts];
    int maxLen;
    maxLen = 0;
    for (int p = 0; p < numPorts; p++)
    begin
      lens[p] = (len == 0) ? int'($urandom % 6) + 1 : len;
      if (mask[p] && lens[p] > maxLen)
        maxLen = lens[p];
    end
    for (int k = 0; k < maxLen; k++)
    begin
      for (int p = 0; p < numPorts; p++)
      begin
        if (mask[p] && k < lens[p])
        begin
          inFlit[p] = makeFlit(p, k, lens[p]);
          inValid[p] = 1'b1;
          expQ[p].push_back(inFlit[p]);
        end
        else if (mask[p])
          inValid[p] = 1'b0;  // this port's packet is already complete.
      end
      @(negedge clk);
      if (gap > 0 && k < maxLen - 1)
      begin
        inValid = inValid & ~mask;
        repeat (gap) @(negedge clk);
      end
    end
    inValid = inValid & ~mask;
  endtask

  task automatic waitDrain();
    while (pendingFlits() != 0)
      @(posedge clk);
    repeat (2) @(negedge clk);
    assert (grant === '0)
    else failRun($sformatf("error at %0t: grant %b still set after the queues drained",
                           $time, grant));
  endtask

  task automatic checkOrder(input string want, input string what);
    assert (headSeq == want)
    else failRun($sformatf("error at %0t: %s left in port order %s, expected %s",
                           $time, what, headSeq, want));
    headSeq = "";
  endtask

  task automatic idleAfterReset();
    repeat (20)
    begin
      @(negedge clk);
      assert (outValid === 1'b0 && grant === '0)
      else failRun($sformatf("error at %0t: activity with no input, grant %b", $time, grant));
    end
  endtask

  task automatic singlePacketEachPort();
    for (int p = 0; p < numPorts; p++)
    begin
      sendPackets(portVec_t'(1 << p), 0, 0);
      waitDrain();
      checkOrder($sformatf("%0d", p), "single packet");
    end
  endtask

  task automatic allPortsAtOnce();
    sendPackets('1, 0, 0);
    waitDrain();
    checkOrder("01234", "simultaneous packets");
  endtask

  task automatic rotationAfterEast();
    fork
      sendPackets(5'b00100, 6, 3);
      begin
        while (grant !== 5'b00100)
          @(negedge clk);
        sendPackets(5'b11011, 0, 0);  // every other port piles up behind East.
      end
    join
    waitDrain();
    checkOrder("23401", "contention behind East");
  endtask

  task automatic gappedPacketHolds();
    fork
      sendPackets(5'b00001, 6, 3);
      begin
        repeat (4) @(negedge clk);
        sendPackets(5'b01010, 0, 0);  // North and West queue up during the gaps.
      end
    join
    waitDrain();
    checkOrder("013", "gapped Local packet");
  endtask

  task automatic shortPacketsAlternate();
    sendPackets(5'b10000, 1, 0);
    waitDrain();
    checkOrder("4", "lone header");
    repeat (4)
      sendPackets(5'b01010, 1, 0);
    waitDrain();
    checkOrder("13131313", "back-to-back headers");
  endtask

  // a departing flit belongs to the port granted in the cycle before.
  always @(negedge clk)
  begin
    flit_t expFlit;
    int    port;
    if (!rst && outValid)
    begin
      assert ($countones(prevGrant) == 1)
      else failRun($sformatf("error at %0t: output strobe with grant %b", $time, prevGrant));
      port = portIndex(prevGrant);
      assert (expQ[port].size() > 0)
      else failRun($sformatf("error at %0t: unexpected flit from port %0d", $time, port));
      expFlit = expQ[port].pop_front();
      assert (outFlit == expFlit)
      else failRun($sformatf("error at %0t: port %0d sent %h, expected %h",
                             $time, port, outFlit, expFlit));
      if (outFlit.kind == kindHead)
      begin
        assert (pktLeft == 0)
        else failRun($sformatf("error at %0t: header from port %0d cut into port %0d",
                               $time, port, pktPort));
        pktLeft = int'(outFlit.len) - 1;
        pktPort = port;
        headSeq = {headSeq, $sformatf("%0d", port)};
      end
      else
      begin
        assert (pktLeft > 0 && port == pktPort)
        else failRun($sformatf("error at %0t: body flit from port %0d outside its packet",
                               $time, port));
        pktLeft--;
      end
    end
    prevGrant = grant;
  end

  initial
  begin
    repeat (watchdogCycles) @(posedge clk);
    failRun("the run timed out because the router stopped delivering flits");
  end

  initial
  begin
    void'($urandom(32'h238c20e9));
    errorCount = 0;
    pktLeft = 0;
    pktPort = 0;
    headSeq = "";
    prevGrant = '0;
    rst = 1'b1;
    inValid = '0;
    for (int p = 0; p < numPorts; p++)
      inFlit[p] = '0;
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    idleAfterReset();
    singlePacketEachPort();
    allPortsAtOnce();
    rotationAfterEast();
    gappedPacketHolds();
    shortPacketsAlternate();
    if (errorCount == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

//--- sim/router_assert.sv
`timescale 1ns/10ps

module routerAssert (
  input logic                clk,
  input logic                rst,
  input routerPkg::portVec_t grant,
  input routerPkg::portVec_t pop,
  input logic                outValid
);

  // at most one port owns the output.
  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
    else $error("grant %b is not one-hot", grant);

  popInsideGrant: assert property (@(posedge clk) disable iff (rst) (pop & ~grant) == '0)
    else $error("pop %b outside grant %b", pop, grant);

  // the output register puts every departure one cycle behind its pop.
  strobeAfterPop: assert property (@(posedge clk) disable iff (rst) |pop |=> outValid)
    else $error("pop without an output strobe one cycle later");

  noStrobeWithoutPop: assert property (@(posedge clk) disable iff (rst) !(|pop) |=> !outValid)
    else $error("output strobe without a pop one cycle before");

  grantClearedByReset: assert property (@(posedge clk) rst |=> grant == '0)
    else $error("grant %b is not idle after reset", grant);

endmodule

bind outputArbiter routerAssert arbCheck (
  .clk      (clk),
  .rst      (rst),
  .grant    (grant),
  .pop      (pop),
  .outValid (outValid)
);

//--- verilog/routerOutputPort.sv
`timescale 1ns/10ps

module routerOutputPort (
  input  logic                clk,
  input  logic                rst,
  input  routerPkg::flit_t    inFlit [routerPkg::numPorts],
  input  routerPkg::portVec_t inValid,
  output routerPkg::flit_t    outFlit,
  output logic                outValid,
  output routerPkg::portVec_t grant
);

  import routerPkg::*;

  portVec_t request;
  portVec_t pop;
  flit_t    headFlits [numPorts];

  // one queue per input side.
  generate
    for (genvar i = 0; i < numPorts; i++)
    begin : gInQueue
      flitFifo #(
        .entry_t (flit_t)
      ) queue (
        .clk      (clk),
        .rst      (rst),
        .push     (inValid[i]),
        .din      (inFlit[i]),
        .pop      (pop[i]),
        .dout     (headFlits[i]),
        .notEmpty (request[i])
      );
    end
  endgenerate

  outputArbiter arbiter (
    .clk       (clk),
    .rst       (rst),
    .request   (request),
    .headFlits (headFlits),
    .pop       (pop),
    .grant     (grant),
    .outFlit   (outFlit),
    .outValid  (outValid)
  );

endmodule

//--- verilog/outputArbiter.sv
`timescale 1ns/10ps

module outputArbiter (
  input  logic                clk,
  input  logic                rst,
  input  routerPkg::portVec_t request,
  input  routerPkg::flit_t    headFlits [routerPkg::numPorts],
  output routerPkg::portVec_t pop,
  output routerPkg::portVec_t grant,
  output routerPkg::flit_t    outFlit,
  output logic                outValid
);

  import routerPkg::*;

  arbState_t   state;
  arbState_t   nextState;
  portVec_t    timesUp;
  portVec_t    others;
  portVec_t    finished;
  int unsigned curIdx;
  flit_t       selFlit;
  logic        anyPop;

  // First requester at or after port start, in cyclic order.
  // The loop runs backwards so that the lowest offset is written last and wins.
  function automatic arbState_t pickNext(input portVec_t req, input int unsigned start);
    arbState_t   next;
    int unsigned idx;
    next = stateIdle;
    for (int k = numPorts - 1; k >= 0; k--)
    begin
      idx = (start + k) % numPorts;
      if (req[idx])
      begin
        next = '0;
        next[idx + 1] = 1'b1;
      end
    end
    return next;
  endfunction

  // one packet timer per input, all built alike.
  generate
    for (genvar i = 0; i < numPorts; i++)
    begin : gTimer
      packetTimer timer (
        .clk      (clk),
        .rst      (rst),
        .headFlit (headFlits[i]),
        .runTimer (pop[i]),
        .timesUp  (timesUp[i])
      );
    end
  endgenerate

  assign grant = state[numPorts:1];
  assign pop = grant & request;  // the granted queue drains whenever it has a flit.
  assign anyPop = |pop;

  // the granted port is left out so an emptied queue cannot win again at once.
  assign others = request & ~grant;
  assign finished = grant & timesUp;

  always_comb
  begin
    curIdx = 0;
    for (int i = 0; i < numPorts; i++)
    begin
      if (grant[i])
        curIdx = i;
    end
  end

  always_comb
  begin
    nextState = state;
    if ($countones(state) != 1)
      nextState = stateIdle;  // recover from a corrupted state.
    else if (state[0])
      nextState = pickNext(request, 0);
    else if (|finished)
      nextState = pickNext(others, curIdx + 1);  // rotate past the port just served.
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= stateIdle;
    else
      state <= nextState;
  end

  // Output mux. The grant is one-hot, so at most one queue head is picked.
  always_comb
  begin
    selFlit = '0;
    for (int i = 0; i < numPorts; i++)
    begin
      if (grant[i])
        selFlit = headFlits[i];
    end
  end

  always_ff @(posedge clk)
  begin
    if (anyPop)
      outFlit <= selFlit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= anyPop;  // one cycle behind the pop.
  end

endmodule

//--- verilog/packetTimer.sv
`timescale 1ns/10ps

module packetTimer (
  input  logic             clk,
  input  logic             rst,
  input  routerPkg::flit_t headFlit,
  input  logic             runTimer,
  output logic             timesUp
);

  import routerPkg::*;

  logic [lenWidth-1:0] pktLen;
  logic [lenWidth-1:0] count;  // flits of the current packet already gone.
  logic                isHead;
  logic                lastFlit;

  assign isHead = (headFlit.kind == kindHead);

  always_comb
  begin
    if (isHead)
      lastFlit = (headFlit.len <= lenWidth'(1));  // a bare header is its own tail.
    else
      lastFlit = (count + lenWidth'(1) >= pktLen);
  end

  assign timesUp = runTimer & lastFlit;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pktLen <= '0;
      count <= '0;
    end
    else if (runTimer)
    begin
      if (isHead)
        pktLen <= headFlit.len;
      if (lastFlit)
        count <= '0;
      else if (isHead)
        count <= lenWidth'(1);
      else
        count <= count + lenWidth'(1);
    end
  end

endmodule

//--- verilog/flitFifo.sv
`timescale 1ns/10ps

module flitFifo #(
  parameter type entry_t = routerPkg::flit_t
) (
  input  logic   clk,
  input  logic   rst,
  input  logic   push,
  input  entry_t din,
  input  logic   pop,
  output entry_t dout,
  output logic   notEmpty
);

  import routerPkg::*;

  entry_t                  mem [fifoDepth];
  logic [fifoPtrWidth-1:0] wrPtr;
  logic [fifoPtrWidth-1:0] rdPtr;
  logic [fifoPtrWidth:0]   count;
  logic                    doPop;

  assign doPop = pop & notEmpty;  // a pop on an empty queue is ignored.
  assign notEmpty = (count != '0);
  assign dout = mem[rdPtr];  // first-word fall-through.

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wrPtr] <= din;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
      begin
        if (wrPtr == fifoPtrWidth'(fifoDepth - 1))
          wrPtr <= '0;
        else
          wrPtr <= wrPtr + 1'b1;
      end
      if (doPop)
      begin
        if (rdPtr == fifoPtrWidth'(fifoDepth - 1))
          rdPtr <= '0;
        else
          rdPtr <= rdPtr + 1'b1;
      end
      case ({push, doPop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;  // both or neither leaves the fill level alone.
      endcase
    end
  end

endmodule

//--- verilog/routerPkg.sv
package routerPkg;

  localparam int numPorts = 5;  // Local, North, East, West, South.
  localparam int fifoDepth = 16;
  localparam int fifoPtrWidth = $clog2(fifoDepth);

  localparam int lenWidth = 12;
  localparam int portIdWidth = 3;
  localparam int dataWidth = 16;

  typedef enum logic [2:0] {
    kindHead = 3'b001,  // a header carries the packet length.
    kindBody = 3'b010
  } flitKind_t;

  typedef struct packed {
    flitKind_t               kind;
    logic [lenWidth-1:0]     len;      // packet length in flits, header included.
    logic [portIdWidth-1:0]  srcPort;  // only used for tracing.
    logic [dataWidth-1:0]    data;
  } flit_t;

  // one bit per input port.
  typedef logic [numPorts-1:0] portVec_t;

  // Arbiter state. Bit 0 means idle and bit i+1 means port i holds the output.
  typedef logic [numPorts:0] arbState_t;

  localparam arbState_t stateIdle = arbState_t'(1);

endpackage
